/* design/snd_macros.svh */
// ~~~~~~~~~~~~~~~~~~~~
// sound board widths and map
// ~~~~~~~~~~~~~~~~~~~~
`ifndef SND_MACROS_SVH
`define SND_MACROS_SVH

// memory widths
`define SND_ROM_AW 17   // code ROM 128 KB
`define SND_PCM_AW 21   // sample ROM 2 MB
`define SND_RAM_AW 13   // work RAM 8 KB
`define SND_BANK_W 3

// region tags matched against the top address bits
`define SND_RAM_TAG  3'b110      // C000-DFFF on A[15:13]
`define SND_PCM_TAG  5'b11100    // E000-E7FF on A[15:11]
`define SND_FM_TAG   5'b11101    // E800-EFFF
`define SND_MBOX_TAG 5'b11110    // F000-F7FF
`define SND_BANK_TAG 6'b111110   // F800-FBFF on A[15:10]

// data driven by windows with nothing behind them
`define SND_OPEN_BUS 8'hff

// bank byte bit that releases the NMI
`define SND_NMI_CLR_BIT 4

`endif

/* design/snd_bus_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// sound bus types
// ~~~~~~~~~~~~~~~~~~~~
package snd_bus_pkg;

    // one sound CPU access lasting a single cycle
    typedef struct packed {
        logic        strobe;
        logic        we;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } snd_bus_req_t;

    // read return
    typedef struct packed {
        logic       rvalid;
        logic [7:0] rdata;
    } snd_bus_rsp_t;

    // decoded address windows
    typedef enum logic [2:0] {
        rg_rom_fixed,
        rg_rom_bank,
        rg_ram,
        rg_pcm,
        rg_fm,
        rg_mbox,
        rg_bank,
        rg_none
    } snd_region_e;

    // main CPU side of the mailbox
    typedef struct packed {
        logic       we;
        logic [1:0] addr;   // 0 and 1 select the m2s latches
        logic [7:0] wdata;
    } main_req_t;

endpackage

/* design/snd_voice_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// PCM voice types
// ~~~~~~~~~~~~~~~~~~~~
package snd_voice_pkg;

    // programmable state of one voice
    typedef struct packed {
        logic [20:0] start;   // first sample ROM byte
        logic [15:0] length;  // bytes per pass
        logic [7:0]  volume;  // unsigned gain
        logic        loop;
    } pcm_regs_t;

    // scaled output with a strobe per new value
    typedef struct packed {
        logic               stb;
        logic signed [15:0] value;
    } pcm_sample_t;

endpackage

/* design/snd_map.sv */
// ~~~~~~~~~~~~~~~~~~~~
// sound memory map
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_map
    import snd_bus_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  snd_bus_req_t           bus_req,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    input  logic                   fm_irq,
    input  logic [7:0]             pcm_rdata,
    input  logic [7:0]             mbox_rdata,
    output snd_bus_rsp_t           bus_rsp,
    output logic                   rom_cs,
    output logic [`SND_ROM_AW-1:0] rom_addr,
    output logic                   pcm_sel,
    output logic                   mbox_sel,
    output logic                   nmi_n
);

    snd_region_e            region;
    snd_region_e            pend_rg;   // window of the last read
    logic                   rd_stb;
    logic                   wr_stb;
    logic                   is_rom;
    logic                   bank_we;
    logic [`SND_BANK_W-1:0] bank;
    logic [7:0]             ram [0:(1 << `SND_RAM_AW)-1];
    logic [7:0]             ram_q;
    logic [7:0]             rom_q;
    logic                   fast_pend;
    logic                   rom_done;
    logic                   fm_irq_l;

    always_comb begin
        if (!bus_req.addr[15])
            region = rg_rom_fixed;
        else if (bus_req.addr[15:14] == 2'b10)
            region = rg_rom_bank;
        else if (bus_req.addr[15:13] == `SND_RAM_TAG)
            region = rg_ram;
        else if (bus_req.addr[15:11] == `SND_PCM_TAG)
            region = rg_pcm;
        else if (bus_req.addr[15:11] == `SND_FM_TAG)
            region = rg_fm;
        else if (bus_req.addr[15:11] == `SND_MBOX_TAG)
            region = rg_mbox;
        else if (bus_req.addr[15:10] == `SND_BANK_TAG)
            region = rg_bank;
        else
            region = rg_none;  // FC00 and up
    end

    assign rd_stb   = bus_req.strobe && !bus_req.we;
    assign wr_stb   = bus_req.strobe && bus_req.we;
    assign is_rom   = region == rg_rom_fixed || region == rg_rom_bank;
    assign pcm_sel  = bus_req.strobe && region == rg_pcm;
    assign mbox_sel = bus_req.strobe && region == rg_mbox;
    assign bank_we  = wr_stb && region == rg_bank;

    // work RAM
    always_ff @(posedge clk) begin
        if (wr_stb && region == rg_ram)
            ram[bus_req.addr[`SND_RAM_AW-1:0]] <= bus_req.wdata;
        if (rd_stb)
            ram_q <= ram[bus_req.addr[`SND_RAM_AW-1:0]];
    end

    // bank register and NMI edge latch
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank     <= '0;
            fm_irq_l <= 1'b0;
            nmi_n    <= 1'b1;
        end else begin
            fm_irq_l <= fm_irq;
            if (bank_we) begin
                bank <= bus_req.wdata[`SND_BANK_W-1:0];
                if (bus_req.wdata[`SND_NMI_CLR_BIT])
                    nmi_n <= 1'b1;
            end
            if (fm_irq && !fm_irq_l)
                nmi_n <= 1'b0;  // a fresh edge beats a clear
        end
    end

    // pending read state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            fast_pend <= 1'b0;
            rom_done  <= 1'b0;
        end else begin
            fast_pend <= rd_stb && !is_rom;
            rom_done  <= rom_cs && rom_ok;
            if (rd_stb && is_rom)
                rom_cs <= 1'b1;
            else if (rom_ok)
                rom_cs <= 1'b0;  // hold until the ROM answers
        end
    end

    always_ff @(posedge clk) begin
        if (rd_stb) begin
            pend_rg <= region;
            if (region == rg_rom_bank)
                rom_addr <= {bank, bus_req.addr[13:0]};
            else
                rom_addr <= {{(`SND_ROM_AW-15){1'b0}}, bus_req.addr[14:0]};
        end
        if (rom_cs && rom_ok)
            rom_q <= rom_data;
    end

    // read return mux
    always_comb begin
        bus_rsp.rvalid = fast_pend || rom_done;
        if (rom_done)
            bus_rsp.rdata = rom_q;
        else begin
            case (pend_rg)
                rg_ram:  bus_rsp.rdata = ram_q;
                rg_pcm:  bus_rsp.rdata = pcm_rdata;
                rg_mbox: bus_rsp.rdata = mbox_rdata;
                default: bus_rsp.rdata = `SND_OPEN_BUS;  // FM, bank, unmapped
            endcase
        end
    end

endmodule

/* design/snd_mailbox.sv */
// ~~~~~~~~~~~~~~~~~~~~
// main/sound mailbox
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module snd_mailbox
    import snd_bus_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  main_req_t    main_req,
    input  logic         main_we,
    input  logic         sel,
    input  snd_bus_req_t bus_req,
    input  logic         snd_irq,
    output logic [7:0]   rdata,
    output logic [7:0]   pair_dout,
    output logic         int_n
);

    logic [1:0][7:0] m2s;     // main to sound
    logic [7:0]      s2m;     // sound to main
    logic            main_wr;
    logic            snd_wr;
    logic            snd_rd;
    logic            int_ack;
    logic            irq_l;

    assign main_wr   = main_we && main_req.we && !main_req.addr[1];
    assign snd_wr    = sel && bus_req.we && bus_req.addr[1:0] == 2'd2;
    assign snd_rd    = sel && !bus_req.we;
    assign int_ack   = snd_rd && bus_req.addr[1:0] == 2'd3;
    assign pair_dout = s2m;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            m2s <= '0;
            s2m <= 8'h00;
        end else begin
            if (main_wr)
                m2s[main_req.addr[0]] <= main_req.wdata;
            if (snd_wr)
                s2m <= bus_req.wdata;
        end
    end

    // snd_irq edge pulls int_n low
    // until the sound CPU reads offset 3
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_l <= 1'b0;
            int_n <= 1'b1;
        end else begin
            irq_l <= snd_irq;
            if (int_ack)
                int_n <= 1'b1;
            if (snd_irq && !irq_l)
                int_n <= 1'b0;
        end
    end

    // registered so it lines up with the map's one-cycle return
    always_ff @(posedge clk) begin
        if (snd_rd) begin
            case (bus_req.addr[1:0])
                2'd0:    rdata <= m2s[0];
                2'd1:    rdata <= m2s[1];
                2'd2:    rdata <= s2m;      // own latch readback
                default: rdata <= 8'h00;    // ack read
            endcase
        end
    end

endmodule

/* design/snd_pcm_voice.sv */
// ~~~~~~~~~~~~~~~~~~~~
// single PCM voice
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_pcm_voice
    import snd_bus_pkg::*;
    import snd_voice_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen_pcm,
    input  logic                   sel,
    input  snd_bus_req_t           bus_req,
    input  logic [7:0]             pcm_data,
    output logic [7:0]             rdata,
    output logic                   pcm_cs,
    output logic [`SND_PCM_AW-1:0] pcm_addr,
    output pcm_sample_t            sample
);

    pcm_regs_t              regs;
    logic                   busy;
    logic [`SND_PCM_AW-1:0] pos;
    logic [15:0]            cnt;     // bytes left in this pass
    logic                   wr;
    logic                   rd;
    logic                   key_on;
    logic                   step;
    logic                   last;
    logic                   fetch_v; // ROM byte arrives this cycle
    logic                   smp_stb;
    logic signed [15:0]     smp_val;
    logic signed [16:0]     product;

    assign wr       = sel && bus_req.we;
    assign rd       = sel && !bus_req.we;
    assign key_on   = wr && bus_req.addr[2:0] == 3'd6 && bus_req.wdata[0];
    assign step     = cen_pcm && busy;
    assign last     = cnt == 16'd1;
    assign pcm_cs   = step;
    assign pcm_addr = pos;
    // signed byte times unsigned volume
    assign product  = $signed(pcm_data) * $signed({1'b0, regs.volume});
    assign sample   = '{stb: smp_stb, value: smp_val};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            regs    <= '0;
            busy    <= 1'b0;
            fetch_v <= 1'b0;
            smp_stb <= 1'b0;
        end else begin
            fetch_v <= step;
            smp_stb <= fetch_v;
            if (wr) begin
                case (bus_req.addr[2:0])
                    3'd0:    regs.start[7:0]   <= bus_req.wdata;
                    3'd1:    regs.start[15:8]  <= bus_req.wdata;
                    3'd2:    regs.start[20:16] <= bus_req.wdata[4:0];
                    3'd3:    regs.length[7:0]  <= bus_req.wdata;
                    3'd4:    regs.length[15:8] <= bus_req.wdata;
                    3'd5:    regs.volume       <= bus_req.wdata;
                    3'd6:    regs.loop         <= bus_req.wdata[1];
                    default: regs              <= regs;  // status offset
                endcase
            end
            if (key_on)
                busy <= |regs.length;   // zero length stays idle
            else if (step && last && !regs.loop)
                busy <= 1'b0;
        end
    end

    // position and count reload on key-on and at the end of a pass
    always_ff @(posedge clk) begin
        if (key_on || (step && last)) begin
            pos <= regs.start;
            cnt <= regs.length;
        end else if (step) begin
            pos <= pos + 1'b1;
            cnt <= cnt - 1'b1;
        end
        if (fetch_v)
            smp_val <= product[15:0];
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            case (bus_req.addr[2:0])
                3'd0:    rdata <= regs.start[7:0];
                3'd1:    rdata <= regs.start[15:8];
                3'd2:    rdata <= {3'd0, regs.start[20:16]};
                3'd3:    rdata <= regs.length[7:0];
                3'd4:    rdata <= regs.length[15:8];
                3'd5:    rdata <= regs.volume;
                3'd6:    rdata <= {6'd0, regs.loop, 1'b0};  // key-on reads 0
                default: rdata <= {7'd0, busy};
            endcase
        end
    end

endmodule

/* design/snd_board.sv */
// ~~~~~~~~~~~~~~~~~~~~
// sound board top
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_board
    import snd_bus_pkg::*;
    import snd_voice_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cen_pcm,
    input  snd_bus_req_t           bus_req,
    input  main_req_t              main_req,
    input  logic                   main_we,
    input  logic                   snd_irq,
    input  logic                   fm_irq,
    input  logic [7:0]             rom_data,
    input  logic                   rom_ok,
    input  logic [7:0]             pcm_data,
    output snd_bus_rsp_t           bus_rsp,
    output logic                   rom_cs,
    output logic [`SND_ROM_AW-1:0] rom_addr,
    output logic                   pcm_cs,
    output logic [`SND_PCM_AW-1:0] pcm_addr,
    output logic [7:0]             pair_dout,
    output logic                   int_n,
    output logic                   nmi_n,
    output pcm_sample_t            sample
);

    logic       pcm_sel;
    logic       mbox_sel;
    logic [7:0] pcm_rdata;
    logic [7:0] mbox_rdata;

    snd_map u_map (
        .clk        (clk),
        .rst        (rst),
        .bus_req    (bus_req),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .fm_irq     (fm_irq),
        .pcm_rdata  (pcm_rdata),
        .mbox_rdata (mbox_rdata),
        .bus_rsp    (bus_rsp),
        .rom_cs     (rom_cs),
        .rom_addr   (rom_addr),
        .pcm_sel    (pcm_sel),
        .mbox_sel   (mbox_sel),
        .nmi_n      (nmi_n)
    );

    snd_mailbox u_mbox (
        .clk       (clk),
        .rst       (rst),
        .main_req  (main_req),
        .main_we   (main_we),
        .sel       (mbox_sel),
        .bus_req   (bus_req),
        .snd_irq   (snd_irq),
        .rdata     (mbox_rdata),
        .pair_dout (pair_dout),
        .int_n     (int_n)
    );

    snd_pcm_voice u_voice (
        .clk      (clk),
        .rst      (rst),
        .cen_pcm  (cen_pcm),
        .sel      (pcm_sel),
        .bus_req  (bus_req),
        .pcm_data (pcm_data),
        .rdata    (pcm_rdata),
        .pcm_cs   (pcm_cs),
        .pcm_addr (pcm_addr),
        .sample   (sample)
    );

endmodule

/* dv/snd_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// sound board testbench
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "snd_macros.svh"

module snd_tb
    import snd_bus_pkg::*;
    import snd_voice_pkg::*;
();

    localparam int max_cycles = 20000;  // about twice the cycles of all tests

    logic                   clk, rst, cen_pcm, main_we, snd_irq, fm_irq, rom_ok, rom_cs;
    logic                   pcm_cs, int_n, nmi_n;
    snd_bus_req_t           bus_req;
    snd_bus_rsp_t           bus_rsp;
    main_req_t              main_req;
    logic [7:0]             rom_data, pcm_data, pair_dout;
    logic [`SND_ROM_AW-1:0] rom_addr;
    logic [`SND_PCM_AW-1:0] pcm_addr;
    pcm_sample_t            sample;

    // reference model
    logic [7:0]             ram_m [0:(1 << `SND_RAM_AW)-1];
    logic [12:0]            ram_used [$];
    logic [2:0]             m_bank;
    logic                   m_nmi_n, m_int_n;
    logic [7:0]             m_m2s [0:1];
    logic [7:0]             m_s2m;
    logic [20:0]            v_start, v_pos;
    logic [15:0]            v_len, v_cnt;
    logic [7:0]             v_vol;
    logic                   v_loop, v_busy;
    int                     stb_seen, wraps, n_checks, n_errors, cycles;

    snd_board uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [7:0] rom_byte(input logic [16:0] a);
        return (a[7:0] + 8'h3c) ^ a[15:8] ^ {a[16], 7'h15};
    endfunction

    function automatic logic [7:0] pcm_byte(input logic [20:0] a);
        return a[7:0] ^ a[15:8] ^ {3'b011, a[20:16]};
    endfunction

    // signed sample byte times unsigned volume
    function automatic logic [15:0] scaled(input logic [7:0] b, input logic [7:0] vol);
        int sb;
        int p;
        sb = int'(b);
        if (b[7])
            sb = sb - 256;
        p = sb * int'(vol);
        return p[15:0];
    endfunction

    function automatic logic [15:0] window(input logic [15:0] base, input logic [15:0] mask,
                                           input logic [15:0] off);
        return base | (16'($urandom) & mask) | off;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            n_errors++;
            $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic voice_reg_write(input logic [2:0] off, input logic [7:0] d);
        case (off)
            3'd0: v_start[7:0] = d;
            3'd1: v_start[15:8] = d;
            3'd2: v_start[20:16] = d[4:0];
            3'd3: v_len[7:0] = d;
            3'd4: v_len[15:8] = d;
            3'd5: v_vol = d;
            3'd6: begin
                v_loop = d[1];
                if (d[0]) begin
                    v_busy = v_len != 0;
                    v_pos  = v_start;
                    v_cnt  = v_len;
                end
            end
            default: ;
        endcase
    endtask

    // every bus task starts and ends on a falling edge
    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        bus_req = '{strobe: 1'b1, we: 1'b1, addr: a, wdata: d};
        @(negedge clk);
        bus_req.strobe = 1'b0;
        expect_eq("rvalid", bus_rsp.rvalid, 0);
        if (a[15:13] == 3'b110)
            ram_m[a[12:0]] = d;
        else if (a[15:10] == 6'b111110) begin
            m_bank = d[2:0];
            if (d[4])
                m_nmi_n = 1'b1;
        end else if (a[15:11] == 5'b11110 && a[1:0] == 2'd2)
            m_s2m = d;
        else if (a[15:11] == 5'b11100)
            voice_reg_write(a[2:0], d);
    endtask

    task automatic bus_fetch(input logic [15:0] a, output logic [7:0] d);
        bus_req = '{strobe: 1'b1, we: 1'b0, addr: a, wdata: 8'h00};
        @(negedge clk);
        bus_req.strobe = 1'b0;
        expect_eq("rvalid", bus_rsp.rvalid, 1);
        d = bus_rsp.rdata;
        if (a[15:11] == 5'b11110 && a[1:0] == 2'd3)
            m_int_n = 1'b1;
    endtask

    task automatic read_check(input logic [15:0] a, input logic [7:0] exp);
        logic [7:0] d;
        bus_fetch(a, d);
        expect_eq("rdata", d, exp);
    endtask

    task automatic rom_read(input logic [15:0] a);
        logic [16:0] exp_ra;
        int          delay;
        int          k;
        exp_ra = a[15] ? {m_bank, a[13:0]} : {2'b00, a[14:0]};
        delay = $urandom % 4;
        bus_req = '{strobe: 1'b1, we: 1'b0, addr: a, wdata: 8'h00};
        @(negedge clk);
        bus_req.strobe = 1'b0;
        for (k = 0; k <= delay; k++) begin
            expect_eq("rom_cs", rom_cs, 1);
            expect_eq("rom_addr", rom_addr, exp_ra);
            expect_eq("rvalid", bus_rsp.rvalid, 0);
            rom_ok = k == delay;
            rom_data = rom_ok ? rom_byte(rom_addr) : 8'($urandom);
            @(negedge clk);
        end
        rom_ok = 1'b0;
        expect_eq("rvalid", bus_rsp.rvalid, 1);
        expect_eq("rdata", bus_rsp.rdata, rom_byte(exp_ra));
        expect_eq("rom_cs", rom_cs, 0);
    endtask

    task automatic wait_voice_idle();
        logic [7:0] st;
        st = 8'h01;
        while (st[0])
            bus_fetch(window(16'he000, 16'h07f8, 16'd7), st);
    endtask

    task automatic play_voice(input logic loop_on);
        logic [15:0] len;
        len = loop_on ? 16'(8 + $urandom % 25) : 16'(64 + $urandom % 192);
        bus_write(window(16'he000, 16'h07f8, 16'd0), 8'($urandom));
        bus_write(window(16'he000, 16'h07f8, 16'd1), 8'($urandom));
        bus_write(window(16'he000, 16'h07f8, 16'd2), 8'($urandom));
        bus_write(window(16'he000, 16'h07f8, 16'd3), len[7:0]);
        bus_write(window(16'he000, 16'h07f8, 16'd4), len[15:8]);
        bus_write(window(16'he000, 16'h07f8, 16'd5), 8'($urandom));
        stb_seen = 0;
        wraps    = 0;
        bus_write(window(16'he000, 16'h07f8, 16'd6), {6'd0, loop_on, 1'b1});
        if (loop_on) begin
            while (stb_seen < 2 * len + 3)
                @(negedge clk);
            bus_write(window(16'he000, 16'h07f8, 16'd6), 8'h00);  // let the pass finish
        end
        wait_voice_idle();
        repeat (3) @(negedge clk);  // last strobe trails busy
        read_check(window(16'he000, 16'h07f8, 16'd7), {7'd0, v_busy});
        if (loop_on)
            expect_eq("loop wraps", wraps >= 2, 1);
        else
            expect_eq("sample count", stb_seen, len);
    endtask

    // cen_pcm source, sample ROM and sample checks
    initial begin : pcm_source
        int          phase;
        logic        f1, f2;
        logic [20:0] a1;
        logic [15:0] e1, e2;
        phase = 0;
        f1 = 1'b0;
        f2 = 1'b0;
        a1 = '0;
        e1 = '0;
        e2 = '0;
        @(negedge rst);
        forever begin
            @(negedge clk);
            expect_eq("sample.stb", sample.stb, f2);
            if (f2)
                expect_eq("sample.value", $unsigned(sample.value), e2);
            if (sample.stb)
                stb_seen++;
            f2 = f1;
            e2 = e1;
            if (f1)
                pcm_data = pcm_byte(a1);  // ROM answers the cycle after pcm_cs
            f1 = 1'b0;
            cen_pcm = phase == 0;
            phase = (phase == 5) ? 0 : phase + 1;
            if (cen_pcm) begin
                #1;
                expect_eq("pcm_cs", pcm_cs, v_busy);
                if (v_busy) begin
                    expect_eq("pcm_addr", pcm_addr, v_pos);
                    if (pcm_addr == v_start && stb_seen > 0)
                        wraps++;  // DUT back at the start address
                    f1 = 1'b1;
                    a1 = pcm_addr;
                    e1 = scaled(pcm_byte(v_pos), v_vol);
                    if (v_cnt == 16'd1) begin
                        v_pos = v_start;
                        v_cnt = v_len;
                        if (!v_loop)
                            v_busy = 1'b0;
                    end else begin
                        v_pos = v_pos + 1'b1;
                        v_cnt = v_cnt - 1'b1;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", max_cycles);
        $display("** FAIL **");
        $finish;
    end

    initial begin : main
        logic [12:0] ra;
        int          i;
        void'($urandom(3040));
        rst = 1'b1;
        cen_pcm = 1'b0;
        bus_req = '0;
        main_req = '0;
        main_we = 1'b0;
        snd_irq = 1'b0;
        fm_irq = 1'b0;
        rom_data = 8'h00;
        rom_ok = 1'b0;
        pcm_data = 8'h00;
        m_bank = '0;
        m_nmi_n = 1'b1;
        m_int_n = 1'b1;
        m_m2s[0] = 8'h00;
        m_m2s[1] = 8'h00;
        m_s2m = 8'h00;
        {v_start, v_pos, v_len, v_cnt, v_vol, v_loop, v_busy} = '0;
        n_checks = 0;
        n_errors = 0;
        stb_seen = 0;
        wraps = 0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        expect_eq("nmi_n", nmi_n, 1);
        expect_eq("int_n", int_n, 1);
        expect_eq("rom_cs", rom_cs, 0);
        expect_eq("rvalid", bus_rsp.rvalid, 0);
        expect_eq("pair_dout", pair_dout, 0);

        // work RAM, mixed writes and reads
        for (i = 0; i < 600; i++) begin
            if (ram_used.size() == 0 || $urandom % 2) begin
                ra = 13'($urandom);
                bus_write({3'b110, ra}, 8'($urandom));
                ram_used.push_back(ra);
            end else begin
                ra = ram_used[$urandom % ram_used.size()];
                read_check({3'b110, ra}, ram_m[ra]);
            end
        end

        // banked and fixed ROM, open windows
        for (i = 0; i < 150; i++) begin
            if (i % 5 == 0)
                bus_write(window(16'hf800, 16'h03ff, 16'd0), 8'($urandom));
            rom_read(16'h8000 | 16'(14'($urandom)));
            rom_read(16'(15'($urandom)));
        end
        for (i = 0; i < 20; i++) begin
            read_check(window(16'he800, 16'h07ff, 16'd0), 8'hff);
            read_check(window(16'hfc00, 16'h03ff, 16'd0), 8'hff);
        end

        // NMI edge latch
        fm_irq = 1'b1;
        @(negedge clk);
        m_nmi_n = 1'b0;
        fm_irq = 1'b0;
        expect_eq("nmi_n", nmi_n, m_nmi_n);
        bus_write(window(16'hf800, 16'h03ff, 16'd0), 8'($urandom) & 8'hef);
        expect_eq("nmi_n", nmi_n, m_nmi_n);
        bus_write(window(16'hf800, 16'h03ff, 16'd0), 8'($urandom) | 8'h10);
        expect_eq("nmi_n", nmi_n, m_nmi_n);

        // mailbox both ways
        for (i = 0; i < 16; i++) begin
            main_req = '{we: 1'b1, addr: 2'(i % 2), wdata: 8'($urandom)};
            main_we = 1'b1;
            m_m2s[i % 2] = main_req.wdata;
            @(negedge clk);
            main_we = 1'b0;
            read_check(window(16'hf000, 16'h07fc, 16'(i % 2)), m_m2s[i % 2]);
            bus_write(window(16'hf000, 16'h07fc, 16'd2), 8'($urandom));
            expect_eq("pair_dout", pair_dout, m_s2m);
        end
        snd_irq = 1'b1;
        @(negedge clk);
        m_int_n = 1'b0;
        snd_irq = 1'b0;
        expect_eq("int_n", int_n, m_int_n);
        read_check(window(16'hf000, 16'h07fc, 16'd3), 8'h00);
        expect_eq("int_n", int_n, m_int_n);

        // PCM voice
        for (i = 0; i < 5; i++)
            play_voice(1'b0);
        play_voice(1'b1);

        repeat (2) @(negedge clk);
        $display("checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+design
design/snd_bus_pkg.sv
design/snd_voice_pkg.sv
design/snd_map.sv
design/snd_mailbox.sv
design/snd_pcm_voice.sv
design/snd_board.sv
dv/snd_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the sound board testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module snd_tb \
    -Mdir obj_dir -o snd_tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat build.log
    echo "build failed with status $status"
    exit 1
fi

./obj_dir/snd_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\* PASS \*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
